/* dv/vid_main_asserts.sv */
// vid_main_asserts: vram handshake and interrupt strobe assertions, bound into vid_main

`default_nettype none

module vid_main_asserts (
    input wire logic           clk,
    input wire logic           reset_i,
    input wire logic           req_i,
    input wire logic           ack_i,
    input wire logic           intr_i,          // bus_intr_o of the top level
    input wire vid_pkg::intr_t intr_signal_i,   // raw sources
    input wire vid_pkg::intr_t intr_mask_i
);

timeunit 1ns;
timeprecision 1ps;

import vid_pkg::*;

int fail_cnt = 0;   // failed assertion count

// req held until the arbiter answers
req_held: assert property (@(posedge clk) disable iff (reset_i) req_i && !ack_i |=> req_i)
    else begin
        $error("req dropped before ack");
        fail_cnt++;
    end

ack_needs_req: assert property (@(posedge clk) disable iff (reset_i) $rose(ack_i) |-> $past(req_i))
    else begin
        $error("ack rose without req");
        fail_cnt++;
    end

// strobe only from a source that was masked in
intr_masked: assert property (@(posedge clk) disable iff (reset_i)
    intr_i |-> $past(|(intr_signal_i & intr_mask_i)))
    else begin
        $error("interrupt strobe for a masked source");
        fail_cnt++;
    end

endmodule

bind vid_main vid_main_asserts asserts_inst (
    .clk(clk),
    .reset_i(reset_i),
    .req_i(vram_req),
    .ack_i(vram_ack),
    .intr_i(bus_intr_o),
    .intr_signal_i(intr_signal),
    .intr_mask_i(intr_mask)
);

`default_nettype wire

/* dv/vid_main_tb.sv */
// clock, reset, bus tasks, reference model, compare tasks, timeout and verdict for vid_main

`default_nettype none

`include "vid_macros.svh"

module vid_main_tb;

timeunit 1ns;
timeprecision 1ps;

import vid_pkg::*;

localparam int FRAME      = `VID_H_TOTAL * `VID_V_TOTAL;    // 288 cycles
localparam int ACTIVE_PIX = `VID_H_ACTIVE * `VID_V_ACTIVE;  // 128 pixels in 32 words
localparam int LIMIT      = 12 * FRAME + 2000;              // cycle budget

logic       clk = 1'b0;
logic       reset_i;
logic       bus_cs_n_i;
logic       bus_rd_nwr_i;
reg_num_t   bus_reg_num_i;
logic       bus_bytesel_i;
logic [7:0] bus_data_i;
logic [7:0] bus_data_o;
logic       bus_intr_o;
rgb_t       rgb_o;
logic       hsync_o;
logic       vsync_o;
logic       dv_de_o;

word_t  vram_model [1 << `VID_VRAM_AW];   // model copy of vram
rgb_t   pal_model [`VID_PAL_SIZE];
integer seed;
int     cycle_cnt = 0;
int     intr_cnt = 0;                      // bus_intr_o pulses seen
logic   video_on = 1'b0;                   // frame compare window
int     pix_idx;
int     de_cnt;
int     hs_cnt;
int     hs_rise;
int     vs_cnt;
logic   hs_prev = 1'b0;

vid_main vid_main_inst (.*);

always #10 clk = ~clk;   // 20 ns period

task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "run stopped");
endtask

task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
        abort_run($sformatf("CHECK FAILED at %0d ns: %s, got %h expected %h",
                            $time, what, got, exp));
    end
endtask

task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
    if (got !== exp) begin
        abort_run($sformatf("CHECK FAILED at %0d ns: %s, got %h expected %h",
                            $time, what, got, exp));
    end
endtask

task automatic check_intr(input intr_t got, input intr_t exp, input string what);
    if (got !== exp) begin
        abort_run($sformatf("CHECK FAILED at %0d ns: %s, got %b expected %b",
                            $time, what, got, exp));
    end
endtask

// palette entry of the nibble at raster position k with the high nibble first
function automatic rgb_t expected_pixel(input int k);
    word_t    w;
    pal_idx_t n;
    w = vram_model[k / 4];
    n = pal_idx_t'(w >> (12 - 4 * (k % 4)));
    return pal_model[n];
endfunction

// one byte access that starts and returns on a falling edge
task automatic bus_cycle(input logic rd, input reg_num_t num, input logic odd,
                         input logic [7:0] din, output logic [7:0] dout);
    bus_cs_n_i    = 1'b0;
    bus_rd_nwr_i  = rd;
    bus_reg_num_i = num;
    bus_bytesel_i = odd;
    bus_data_i    = din;
    @(negedge clk);
    bus_cs_n_i = 1'b1;       // one idle sample before next access
    @(negedge clk);
    dout = bus_data_o;
endtask

task automatic reg_write(input reg_num_t num, input word_t value);
    logic [7:0] unused;
    bus_cycle(1'b0, num, 1'b0, value[15:8], unused);
    bus_cycle(1'b0, num, 1'b1, value[7:0], unused);   // odd byte commits
endtask

task automatic reg_read(input reg_num_t num, output word_t value);
    logic [7:0] hi;
    logic [7:0] lo;
    bus_cycle(1'b1, num, 1'b0, 8'h00, hi);
    bus_cycle(1'b1, num, 1'b1, 8'h00, lo);
    value = {hi, lo};
endtask

task automatic wait_idle();
    word_t s;
    reg_read(REG_STATUS, s);
    while (s[0]) begin
        reg_read(REG_STATUS, s);    // busy bit
    end
endtask

task automatic vram_fill(input int base, input int n);
    word_t w;
    reg_write(REG_WR_ADDR, word_t'(base));
    for (int i = 0; i < n; i++) begin
        w = word_t'($random(seed));
        vram_model[base + i] = w;
        reg_write(REG_WR_DATA, w);   // address steps by itself
        wait_idle();
    end
endtask

task automatic vram_verify(input int base, input int n);
    word_t w;
    for (int i = 0; i < n; i++) begin
        reg_write(REG_RD_ADDR, word_t'(base + i));
        wait_idle();
        reg_read(REG_RD_DATA, w);
        check_word(w, vram_model[base + i], $sformatf("vram word %0d", base + i));
    end
endtask

task automatic wait_vsync();
    @(posedge vsync_o);
    @(negedge clk);
endtask

always @(posedge clk) begin
    cycle_cnt++;
    if (bus_intr_o) begin
        intr_cnt++;     // pulse of the previous cycle
    end
    if (cycle_cnt > LIMIT) begin
        abort_run($sformatf("timeout: run did not finish within %0d cycles", LIMIT));
    end
end

always @(negedge clk) begin
    if (vid_main_inst.asserts_inst.fail_cnt != 0) begin
        abort_run("an assertion on vid_main failed");
    end
end

// frame compare against the model on the falling edge where outputs are stable
always @(negedge clk) begin
    if (video_on) begin
        if (dv_de_o) begin
            check_rgb(rgb_o, expected_pixel(pix_idx), $sformatf("pixel %0d", pix_idx));
            pix_idx++;
            de_cnt++;
        end else begin
            check_rgb(rgb_o, '0, "rgb outside display enable");
        end
        if (hsync_o) begin
            hs_cnt++;
        end
        if (hsync_o && !hs_prev) begin
            hs_rise++;
        end
        if (vsync_o) begin
            vs_cnt++;
        end
    end
    hs_prev = hsync_o;
end

initial begin
    word_t w;
    int    n0;
    seed          = 32'haf67_86e3;
    reset_i       = 1'b1;
    bus_cs_n_i    = 1'b1;
    bus_rd_nwr_i  = 1'b0;
    bus_reg_num_i = '0;
    bus_bytesel_i = 1'b0;
    bus_data_i    = '0;
    repeat (10) @(negedge clk);
    reset_i = 1'b0;
    check_word(word_t'({bus_intr_o, hsync_o, vsync_o, dv_de_o}), '0, "outputs after reset");
    reg_read(REG_STATUS, w);
    check_word(w, '0, "status after reset");

    // random palette and one frame of pixels
    for (int i = 0; i < `VID_PAL_SIZE; i++) begin
        pal_model[i] = rgb_t'($random(seed));
        reg_write(REG_PAL, {pal_idx_t'(i), pal_model[i]});
    end
    vram_fill(0, ACTIVE_PIX / 4);
    vram_verify(0, ACTIVE_PIX / 4);

    // align to a line start so each vram access lands on a fetch slot
    @(posedge dv_de_o);
    repeat (3) @(negedge clk);
    vram_fill(512, 16);
    vram_verify(512, 16);

    // one whole frame from the vsync edge
    @(posedge vsync_o);
    pix_idx  = 0;
    de_cnt   = 0;
    hs_cnt   = 0;
    hs_rise  = 0;
    vs_cnt   = 0;
    video_on = 1'b1;
    repeat (FRAME) @(posedge clk);
    video_on = 1'b0;
    @(negedge clk);
    check_word(word_t'(de_cnt), word_t'(ACTIVE_PIX), "enabled pixels per frame");
    check_word(word_t'(hs_rise), 16'd12, "hsync pulses per frame");
    check_word(word_t'(hs_cnt), 16'd36, "hsync high cycles per frame");
    check_word(word_t'(vs_cnt), 16'd24, "vsync high cycles per frame");

    // vblank masked in and cleared after each frame
    reg_write(REG_INTR, 16'h0001);
    wait_vsync();
    reg_write(REG_INTR, 16'h0101);
    n0 = intr_cnt;
    repeat (3) begin
        wait_vsync();
        reg_read(REG_INTR, w);
        check_intr(intr_t'(w[1:0]), 2'b01, "vblank status set");
        reg_read(REG_INTR, w);
        check_intr(intr_t'(w[1:0]), 2'b01, "vblank status held");
        reg_write(REG_INTR, 16'h0101);
        reg_read(REG_INTR, w);
        check_intr(intr_t'(w[1:0]), 2'b00, "vblank status cleared");
    end
    check_word(word_t'(intr_cnt - n0), 16'd3, "vblank interrupts over three frames");

    // vblank masked out while status still records it
    reg_write(REG_INTR, 16'h0000);
    n0 = intr_cnt;
    wait_vsync();
    wait_vsync();
    check_word(word_t'(intr_cnt - n0), 16'd0, "vblank interrupt while masked out");
    reg_read(REG_INTR, w);
    check_intr(intr_t'(w[1:0]), 2'b01, "vblank status while masked out");
    reg_write(REG_INTR, 16'h0100);

    // software trigger masked in then out
    reg_write(REG_INTR, 16'h0002);
    n0 = intr_cnt;
    reg_write(REG_INTR, 16'h1002);
    reg_read(REG_INTR, w);
    check_intr(intr_t'(w[1:0]), 2'b10, "software status set");
    check_word(word_t'(intr_cnt - n0), 16'd1, "software interrupt masked in");
    reg_write(REG_INTR, 16'h0300);
    n0 = intr_cnt;
    reg_write(REG_INTR, 16'h1000);
    reg_read(REG_INTR, w);
    check_intr(intr_t'(w[1:0]), 2'b10, "software status while masked out");
    check_word(word_t'(intr_cnt - n0), 16'd0, "software interrupt masked out");

    @(negedge clk);
    if (vid_main_inst.asserts_inst.fail_cnt == 0) begin
        $display(">>> PASS");
        $finish;
    end else begin
        abort_run("an assertion on vid_main failed");
    end
end

endmodule

`default_nettype wire

/* rtl/bus_regs.sv */
// bus_regs: cpu register decode, byte assembly, interrupt control and vram request FSM

`default_nettype none

module bus_regs (
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    input  wire logic                 bus_cs_n_i,       // chip select, active low
    input  wire logic                 bus_rd_nwr_i,     // 1 = read
    input  wire vid_pkg::reg_num_t    bus_reg_num_i,
    input  wire logic                 bus_bytesel_i,    // 0 = even (high) byte
    input  wire logic [7:0]           bus_data_i,
    output logic      [7:0]           bus_data_o,
    output vid_pkg::vram_req_t        vram_req_o,
    output logic                      req_o,
    input  wire logic                 ack_i,
    input  wire vid_pkg::word_t       rd_data_i,
    output vid_pkg::pal_wr_t          pal_wr_o,
    output vid_pkg::intr_t            intr_mask_o,
    output vid_pkg::intr_t            intr_clear_o,     // one cycle strobe
    output vid_pkg::intr_t            intr_soft_o,      // one cycle strobe
    input  wire vid_pkg::intr_t       intr_status_i
);

import vid_pkg::*;

logic        cs_n_q;        // last chip select sample
logic        start;         // access begins this cycle
logic        commit;        // odd byte write completes a word
logic [7:0]  even_q;        // held even byte
word_t       wr_word;
word_t       rd_word;       // register value for readback
regs_state_t state_q;
logic        busy;
logic        req_wr_q;      // pending access is a write
vram_addr_t  wr_addr_q;
vram_addr_t  rd_addr_q;
word_t       wr_data_q;
word_t       rd_data_q;     // last word read from vram

assign start   = cs_n_q & ~bus_cs_n_i;             // high to low edge
assign commit  = start & ~bus_rd_nwr_i & bus_bytesel_i;
assign wr_word = {even_q, bus_data_i};
assign busy    = (state_q != RS_IDLE);
assign req_o   = (state_q == RS_REQ);

// struct only changes in idle, so it is stable while req is high
assign vram_req_o = '{wr: req_wr_q, addr: (req_wr_q ? wr_addr_q : rd_addr_q), data: wr_data_q};

always_comb begin
    case (bus_reg_num_i)
        REG_RD_DATA: rd_word = rd_data_q;
        REG_INTR:    rd_word = {14'b0, intr_status_i};
        REG_STATUS:  rd_word = {15'b0, busy};
        default:     rd_word = '0;                  // write only regs read 0
    endcase
end

// byte capture and read data, no reset needed
always_ff @(posedge clk) begin
    if (start && !bus_rd_nwr_i && !bus_bytesel_i) begin
        even_q <= bus_data_i;
    end
    if (start && bus_rd_nwr_i) begin
        bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];  // held until next read
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        cs_n_q       <= 1'b1;
        state_q      <= RS_IDLE;
        wr_addr_q    <= '0;
        intr_mask_o  <= '0;
        intr_clear_o <= '0;
        intr_soft_o  <= '0;
        pal_wr_o     <= '0;
    end else begin
        cs_n_q       <= bus_cs_n_i;
        intr_clear_o <= '0;
        intr_soft_o  <= '0;
        pal_wr_o.en  <= 1'b0;

        // four phase handshake toward vram_arb
        case (state_q)
            RS_IDLE: begin
                if (commit && (bus_reg_num_i == REG_WR_DATA)) begin
                    wr_data_q <= wr_word;
                    req_wr_q  <= 1'b1;
                    state_q   <= RS_REQ;
                end else if (commit && (bus_reg_num_i == REG_RD_ADDR)) begin
                    rd_addr_q <= vram_addr_t'(wr_word);
                    req_wr_q  <= 1'b0;
                    state_q   <= RS_REQ;
                end
            end
            RS_REQ: begin
                if (ack_i) begin
                    if (req_wr_q) begin
                        wr_addr_q <= wr_addr_q + 1'b1;   // auto increment after write
                    end else begin
                        rd_data_q <= rd_data_i;          // valid while ack high
                    end
                    state_q <= RS_DONE;
                end
            end
            RS_DONE: begin
                if (!ack_i) begin
                    state_q <= RS_IDLE;                  // busy ends here
                end
            end
            default: state_q <= RS_IDLE;
        endcase

        if (commit) begin
            case (bus_reg_num_i)
                REG_WR_ADDR: wr_addr_q <= vram_addr_t'(wr_word);
                REG_INTR: begin
                    intr_mask_o  <= wr_word[1:0];
                    intr_clear_o <= wr_word[9:8];
                    intr_soft_o  <= {wr_word[12], 1'b0};  // software source is bit 1
                end
                REG_PAL:     pal_wr_o <= '{en: 1'b1, idx: wr_word[15:12], rgb: wr_word[11:0]};
                default: ;
            endcase
        end
    end
end

endmodule

`default_nettype wire

/* rtl/pixel_out.sv */
// pixel_out: nibble shifter, palette ram and aligned rgb and sync output stage

`default_nettype none

`include "vid_macros.svh"

module pixel_out (
    input  wire logic             clk,
    input  wire logic             reset_i,
    input  wire vid_pkg::sync_t   sync_i,
    input  wire logic             fetch_en_i,
    input  wire vid_pkg::word_t   fetch_data_i,
    input  wire vid_pkg::pal_wr_t pal_wr_i,
    output vid_pkg::rgb_t         rgb_o,
    output vid_pkg::sync_t        sync_o
);

import vid_pkg::*;

rgb_t     pal_mem [`VID_PAL_SIZE];
logic     load_q;       // fetched word arrives this cycle
word_t    shift_q;      // remaining nibbles of the word
pal_idx_t nibble;
pal_idx_t idx_q;
sync_t    sync_d1;
sync_t    sync_d2;

// high nibble straight from vram on the load cycle
assign nibble = load_q ? fetch_data_i[15:12] : shift_q[15:12];

always_ff @(posedge clk) begin
    shift_q <= load_q ? {fetch_data_i[11:0], 4'h0} : {shift_q[11:0], 4'h0};
    idx_q   <= nibble;
    rgb_o   <= sync_d2.de ? pal_mem[idx_q] : '0;      // black in blanking
end

always_ff @(posedge clk) begin
    if (pal_wr_i.en) begin
        pal_mem[pal_wr_i.idx] <= pal_wr_i.rgb;
    end
end

// sync rides along three stages
always_ff @(posedge clk) begin
    if (reset_i) begin
        load_q  <= 1'b0;
        sync_d1 <= '0;
        sync_d2 <= '0;
        sync_o  <= '0;
    end else begin
        load_q  <= fetch_en_i;
        sync_d1 <= sync_i;
        sync_d2 <= sync_d1;
        sync_o  <= sync_d2;
    end
end

endmodule

`default_nettype wire

/* rtl/vid_macros.svh */
// vram size and tiny display timing defines for the video controller

`ifndef VID_MACROS_SVH
`define VID_MACROS_SVH

// vram is word addressed
`define VID_VRAM_AW         10      // 1024 words

// horizontal timing in pixel clocks
`define VID_H_ACTIVE        16
`define VID_H_TOTAL         24
`define VID_H_SYNC_START    18      // hsync high 18..20
`define VID_H_SYNC_END      21

// vertical timing in lines
`define VID_V_ACTIVE        8
`define VID_V_TOTAL         12
`define VID_V_SYNC_START    9       // vsync high on line 9 only
`define VID_V_SYNC_END      10

`define VID_PAL_SIZE        16      // palette entries

`endif

/* rtl/vid_main.sv */
// vid_main: top level with register, timing, vram and pixel instances plus interrupt logic

`default_nettype none

module vid_main (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire logic              bus_cs_n_i,
    input  wire logic              bus_rd_nwr_i,
    input  wire vid_pkg::reg_num_t bus_reg_num_i,
    input  wire logic              bus_bytesel_i,
    input  wire logic [7:0]        bus_data_i,
    output logic      [7:0]        bus_data_o,
    output logic                   bus_intr_o,     // interrupt strobe
    output vid_pkg::rgb_t          rgb_o,
    output logic                   hsync_o,
    output logic                   vsync_o,
    output logic                   dv_de_o
);

import vid_pkg::*;

vram_req_t vram_cmd;       // cpu access to vram
logic      vram_req;
logic      vram_ack;
word_t     vram_rd_data;
word_t     fetch_data;
fetch_t    fetch;
sync_t     vid_sync;       // at counter position
sync_t     pix_sync;       // aligned with rgb_o
pal_wr_t   pal_wr;
logic      frame;          // vblank source
intr_t     intr_mask;
intr_t     intr_clear;
intr_t     intr_soft;
intr_t     intr_status;
intr_t     intr_signal;

bus_regs bus_regs_inst (
    .clk(clk),
    .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n_i),
    .bus_rd_nwr_i(bus_rd_nwr_i),
    .bus_reg_num_i(bus_reg_num_i),
    .bus_bytesel_i(bus_bytesel_i),
    .bus_data_i(bus_data_i),
    .bus_data_o(bus_data_o),
    .vram_req_o(vram_cmd),
    .req_o(vram_req),
    .ack_i(vram_ack),
    .rd_data_i(vram_rd_data),
    .pal_wr_o(pal_wr),
    .intr_mask_o(intr_mask),
    .intr_clear_o(intr_clear),
    .intr_soft_o(intr_soft),
    .intr_status_i(intr_status)
);

video_timing video_timing_inst (
    .clk(clk),
    .reset_i(reset_i),
    .sync_o(vid_sync),
    .fetch_o(fetch),
    .frame_o(frame)
);

vram_arb vram_arb_inst (
    .clk(clk),
    .fetch_i(fetch),
    .fetch_data_o(fetch_data),
    .vram_req_i(vram_cmd),
    .req_i(vram_req),
    .ack_o(vram_ack),
    .rd_data_o(vram_rd_data)
);

pixel_out pixel_out_inst (
    .clk(clk),
    .reset_i(reset_i),
    .sync_i(vid_sync),
    .fetch_en_i(fetch.en),
    .fetch_data_i(fetch_data),
    .pal_wr_i(pal_wr),
    .rgb_o(rgb_o),
    .sync_o(pix_sync)
);

assign hsync_o = pix_sync.hs;
assign vsync_o = pix_sync.vs;
assign dv_de_o = pix_sync.de;

assign intr_signal = intr_soft | {1'b0, frame};   // bit 0 vblank, bit 1 software

always_ff @(posedge clk) begin
    if (reset_i) begin
        bus_intr_o  <= 1'b0;
        intr_status <= '0;
    end else begin
        bus_intr_o  <= |(intr_signal & intr_mask & ~intr_status);  // only new unmasked sources
        intr_status <= (intr_status | intr_signal) & ~intr_clear;
    end
end

endmodule

`default_nettype wire

/* rtl/vid_pkg.sv */
// vid_pkg with vector typedefs, register numbers, regs state enum and packed structs

`default_nettype none

`include "vid_macros.svh"

package vid_pkg;

typedef logic [15:0]               word_t;       // vram / register word
typedef logic [`VID_VRAM_AW-1:0]   vram_addr_t;
typedef logic [11:0]               rgb_t;        // red in [11:8]
typedef logic [3:0]                pal_idx_t;
typedef logic [3:0]                reg_num_t;
typedef logic [1:0]                intr_t;       // [0] vblank, [1] software
typedef logic [4:0]                hcount_t;
typedef logic [3:0]                vcount_t;

typedef enum logic [1:0] {
    RS_IDLE,                                     // no vram access pending
    RS_REQ,                                      // req high, waiting for ack
    RS_DONE                                      // req dropped, waiting for ack low
} regs_state_t;

typedef struct packed {
    logic       wr;                              // 1 = write, 0 = read
    vram_addr_t addr;
    word_t      data;
} vram_req_t;

typedef struct packed {
    logic     en;                                // one cycle write strobe
    pal_idx_t idx;
    rgb_t     rgb;
} pal_wr_t;

typedef struct packed {
    logic       en;                              // fetch slot
    vram_addr_t addr;
} fetch_t;

typedef struct packed {
    logic hs;
    logic vs;
    logic de;                                    // display enable
} sync_t;

// cpu register numbers
localparam reg_num_t REG_WR_ADDR = 4'd0;
localparam reg_num_t REG_WR_DATA = 4'd1;
localparam reg_num_t REG_RD_ADDR = 4'd2;
localparam reg_num_t REG_RD_DATA = 4'd3;
localparam reg_num_t REG_INTR    = 4'd4;
localparam reg_num_t REG_PAL     = 4'd5;
localparam reg_num_t REG_STATUS  = 4'd7;

endpackage

`default_nettype wire

/* rtl/video_timing.sv */
// video_timing: h/v counters, sync and enable decode, fetch slots and frame strobe

`default_nettype none

`include "vid_macros.svh"

module video_timing (
    input  wire logic       clk,
    input  wire logic       reset_i,
    output vid_pkg::sync_t  sync_o,
    output vid_pkg::fetch_t fetch_o,
    output logic            frame_o        // start of first blank line
);

import vid_pkg::*;

hcount_t    h_q;
vcount_t    v_q;
vram_addr_t fetch_addr_q;  // linear, raster order
logic       h_last;
logic       v_last;
logic       de;

assign h_last = (h_q == hcount_t'(`VID_H_TOTAL - 1));
assign v_last = (v_q == vcount_t'(`VID_V_TOTAL - 1));

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_q <= '0;
        v_q <= '0;
    end else if (h_last) begin
        h_q <= '0;
        v_q <= v_last ? '0 : v_q + 1'b1;
    end else begin
        h_q <= h_q + 1'b1;
    end
end

assign de = (h_q < hcount_t'(`VID_H_ACTIVE)) && (v_q < vcount_t'(`VID_V_ACTIVE));

assign sync_o.hs = (h_q >= hcount_t'(`VID_H_SYNC_START)) && (h_q < hcount_t'(`VID_H_SYNC_END));
assign sync_o.vs = (v_q >= vcount_t'(`VID_V_SYNC_START)) && (v_q < vcount_t'(`VID_V_SYNC_END));
assign sync_o.de = de;

// one word per four pixels
assign fetch_o.en   = de && (h_q[1:0] == 2'b00);
assign fetch_o.addr = fetch_addr_q;

assign frame_o = (v_q == vcount_t'(`VID_V_ACTIVE)) && (h_q == '0);

always_ff @(posedge clk) begin
    if (reset_i) begin
        fetch_addr_q <= '0;
    end else if (frame_o) begin
        fetch_addr_q <= '0;                    // all fetches done, rewind for next frame
    end else if (fetch_o.en) begin
        fetch_addr_q <= fetch_addr_q + 1'b1;
    end
end

endmodule

`default_nettype wire

/* rtl/vram_arb.sv */
// vram_arb: single port vram with video fetch priority and cpu ack handshake

`default_nettype none

`include "vid_macros.svh"

module vram_arb (
    input  wire logic               clk,
    input  wire vid_pkg::fetch_t    fetch_i,
    output vid_pkg::word_t          fetch_data_o,  // valid the cycle after the slot
    input  wire vid_pkg::vram_req_t vram_req_i,
    input  wire logic               req_i,
    output logic                    ack_o,
    output vid_pkg::word_t          rd_data_o      // valid while ack high
);

import vid_pkg::*;

localparam int VRAM_WORDS = 1 << `VID_VRAM_AW;

word_t vram_mem [VRAM_WORDS];
logic  cpu_go;             // serve cpu this cycle

// fetch slots stall the cpu, new request only while ack is low
assign cpu_go = req_i && !ack_o && !fetch_i.en;

// one access per cycle, video first
always_ff @(posedge clk) begin
    if (fetch_i.en) begin
        fetch_data_o <= vram_mem[fetch_i.addr];
    end else if (cpu_go) begin
        if (vram_req_i.wr) begin
            vram_mem[vram_req_i.addr] <= vram_req_i.data;
        end else begin
            rd_data_o <= vram_mem[vram_req_i.addr];
        end
    end
end

// ack follows req, low after req is seen low
always_ff @(posedge clk) begin
    if (cpu_go) begin
        ack_o <= 1'b1;
    end else if (!req_i) begin
        ack_o <= 1'b0;
    end
end

endmodule

`default_nettype wire

/* src.f */
+incdir+rtl
rtl/vid_pkg.sv
rtl/bus_regs.sv
rtl/video_timing.sv
rtl/vram_arb.sv
rtl/pixel_out.sv
rtl/vid_main.sv
dv/vid_main_asserts.sv
dv/vid_main_tb.sv
